// ==== commit_pkg.sv ====
// commit stage package
// shared widths, functional unit and operation encodings, scoreboard entry
// and request structs, plus helpers that classify retiring operations

`default_nettype none

package commit_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    // data and pc width
    localparam int unsigned XLEN            = 32;
    // architectural register address
    localparam int unsigned REG_ADDR_BITS   = 5;
    // scoreboard transaction id
    localparam int unsigned TRANS_ID_BITS   = 3;
    // the commit logic below is written for exactly two ports
    localparam int unsigned NR_COMMIT_PORTS = 2;
    // exception cause word
    localparam int unsigned CAUSE_BITS      = 8;
    // accrued fp exception flags (nv, dz, of, uf, nx)
    localparam int unsigned FFLAGS_BITS     = 5;

    // ------------------------------
    // encodings
    // ------------------------------
    // functional unit that executed the entry
    typedef enum logic [2:0] {
        NONE,
        LOAD,
        STORE,
        ALU,
        CTRL_FLOW,
        MULT,
        CSR,
        FPU
    } fu_t;

    // operation where ADD doubles as the csr no-op
    typedef enum logic [4:0] {
        ADD,
        SUB,
        ANDL,
        ORL,
        XORL,
        SLTS,
        // csr instructions
        CSR_WRITE,
        CSR_READ,
        CSR_SET,
        CSR_CLEAR,
        // memory ordering and tlb maintenance
        FENCE,
        FENCE_I,
        SFENCE_VMA,
        // floating point
        FADD,
        FMUL,
        FCVT_W_S,
        FLD
    } op_t;

    // cause word read as a trap code or as the fflags of an fpu result
    typedef union packed {
        logic [CAUSE_BITS-1:0] code;
        struct packed {
            logic [CAUSE_BITS-FFLAGS_BITS-1:0] pad;
            logic [FFLAGS_BITS-1:0]            fflags;
        } fp;
    } cause_u;

    // ------------------------------
    // structs
    // ------------------------------
    typedef struct packed {
        logic            valid;
        cause_u          cause;
        logic [XLEN-1:0] tval;
    } exception_t;

    // one scoreboard entry as seen at commit
    typedef struct packed {
        logic                     valid;
        logic [XLEN-1:0]          pc;
        logic [TRANS_ID_BITS-1:0] trans_id;
        fu_t                      fu;
        op_t                      op;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [XLEN-1:0]          result;
        exception_t               ex;
    } sb_entry_t;

    // register file write for one commit port
    typedef struct packed {
        logic                     we_gpr;
        logic                     we_fpr;
        logic [REG_ADDR_BITS-1:0] waddr;
        logic [XLEN-1:0]          wdata;
    } rf_write_t;

    // request towards the csr file
    typedef struct packed {
        op_t             op;
        logic [XLEN-1:0] wdata;
        logic            write_fflags;
        logic            commit;
    } csr_req_t;

    // flush requests to the controller
    typedef struct packed {
        logic fence;
        logic fence_i;
        logic sfence_vma;
    } fence_req_t;

    // ------------------------------
    // helpers
    // ------------------------------
    // destination lives in the fp register file
    function automatic logic is_rd_fpr(op_t op);
        return op inside {FADD, FMUL, FLD};
    endfunction

    // executed by the fpu and so may accrue fflags
    function automatic logic is_fpu(fu_t fu);
        return fu == FPU;
    endfunction

endpackage

`default_nettype wire

// ==== commit_stage.sv ====
// two port commit stage
// retires up to two scoreboard entries per cycle into architectural state

`timescale 1ns/1ps
`default_nettype none

module commit_stage import commit_pkg::*; (
    input  wire                                   clk_i,
    input  wire                                   rst_n_i,
    // controller
    input  wire                                   halt_i,
    input  wire                                   flush_dcache_i,
    input  wire                                   single_step_i,
    output exception_t                            exception_o,
    output logic                                  dirty_fp_state_o,
    // scoreboard
    input  wire  sb_entry_t [NR_COMMIT_PORTS-1:0] commit_instr_i,
    output logic [NR_COMMIT_PORTS-1:0]            commit_ack_o,
    // register files
    output rf_write_t [NR_COMMIT_PORTS-1:0]       rf_write_o,
    // csr file and pc gen
    output logic [XLEN-1:0]                       pc_o,
    output csr_req_t                              csr_req_o,
    input  wire  [XLEN-1:0]                       csr_rdata_i,
    input  wire  exception_t                      csr_exception_i,
    // lsu
    output logic                                  commit_lsu_o,
    input  wire                                   commit_lsu_ready_i,
    output logic [TRANS_ID_BITS-1:0]              commit_tran_id_o,
    input  wire                                   no_st_pending_i,
    // flush requests
    output fence_req_t                            fence_req_o
);

    // flags merged from both ports and fed back to port 0
    logic                   fflags_we;
    logic [FFLAGS_BITS-1:0] fflags;

    assign pc_o             = commit_instr_i[0].pc;
    assign commit_tran_id_o = commit_instr_i[0].trans_id;

    // ------------------------------
    // trap and port 0
    // ------------------------------
    trap_select i_trap_select (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .head_i          (commit_instr_i[0]),
        .csr_exception_i (csr_exception_i),
        .halt_i          (halt_i),
        .exception_o     (exception_o)
    );

    head_commit i_head_commit (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .head_i             (commit_instr_i[0]),
        .halt_i             (halt_i),
        .flush_dcache_i     (flush_dcache_i),
        .csr_exception_i    (csr_exception_i),
        .csr_rdata_i        (csr_rdata_i),
        .commit_lsu_ready_i (commit_lsu_ready_i),
        .no_st_pending_i    (no_st_pending_i),
        .fflags_we_i        (fflags_we),
        .fflags_i           (fflags),
        .ack_o              (commit_ack_o[0]),
        .rf_write_o         (rf_write_o[0]),
        .commit_lsu_o       (commit_lsu_o),
        .csr_req_o          (csr_req_o),
        .fence_req_o        (fence_req_o)
    );

    // ------------------------------
    // port 1 and fp state
    // ------------------------------
    second_commit i_second_commit (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .entry_i           (commit_instr_i[1]),
        .head_ack_i        (commit_ack_o[0]),
        .head_fu_i         (commit_instr_i[0].fu),
        .flush_dcache_i    (flush_dcache_i),
        .single_step_i     (single_step_i),
        .exception_valid_i (exception_o.valid),
        .ack_o             (commit_ack_o[1]),
        .rf_write_o        (rf_write_o[1])
    );

    fp_state_commit i_fp_state_commit (
        .entries_i        (commit_instr_i),
        .acks_i           (commit_ack_o),
        .fflags_we_o      (fflags_we),
        .fflags_o         (fflags),
        .dirty_fp_state_o (dirty_fp_state_o)
    );

endmodule

`default_nettype wire

// ==== fp_state_commit.sv ====
// fp state update
// accrues fflags of retiring fpu instructions and marks the fs field dirty

`timescale 1ns/1ps
`default_nettype none

module fp_state_commit import commit_pkg::*; (
    input  wire  sb_entry_t [NR_COMMIT_PORTS-1:0] entries_i,
    input  wire  [NR_COMMIT_PORTS-1:0]            acks_i,
    output logic                                  fflags_we_o,
    output logic [FFLAGS_BITS-1:0]                fflags_o,
    output logic                                  dirty_fp_state_o
);

    always_comb begin
        fflags_we_o      = 1'b0;
        fflags_o         = '0;
        dirty_fp_state_o = 1'b0;
        for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
            // fpu entries carry their flags in the cause word
            if (acks_i[i] && is_fpu(entries_i[i].fu)) begin
                fflags_we_o = 1'b1;
                fflags_o    = fflags_o | entries_i[i].ex.cause.fp.fflags;
            end
            // fpu ops and fp loads both touch fp state
            if (acks_i[i] && (is_fpu(entries_i[i].fu) || is_rd_fpr(entries_i[i].op))) begin
                dirty_fp_state_o = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== head_commit.sv ====
// commit port 0
// retires the oldest entry: register write, store commit, csr commit,
// fence requests and the fflags write towards the csr file

`timescale 1ns/1ps
`default_nettype none

module head_commit import commit_pkg::*; (
    input  wire        clk_i,
    input  wire        rst_n_i,
    input  wire        sb_entry_t  head_i,
    input  wire        halt_i,
    input  wire        flush_dcache_i,
    input  wire        exception_t csr_exception_i,
    input  wire        [XLEN-1:0] csr_rdata_i,
    input  wire        commit_lsu_ready_i,
    input  wire        no_st_pending_i,
    input  wire        fflags_we_i,
    input  wire        [FFLAGS_BITS-1:0] fflags_i,
    output logic       ack_o,
    output rf_write_t  rf_write_o,
    output logic       commit_lsu_o,
    output csr_req_t   csr_req_o,
    output fence_req_t fence_req_o
);

    logic retire_ok;
    logic is_fence;
    logic is_fence_i;
    logic is_sfence;
    logic fence_any;
    logic is_store;
    logic is_csr;
    logic store_gate;
    logic csr_gate;
    logic fence_gate;
    logic ack;

    // ------------------------------
    // classify the head
    // ------------------------------
    // valid, no earlier exception, not halted
    assign retire_ok  = head_i.valid && !head_i.ex.valid && !halt_i;

    assign is_fence   = head_i.op == FENCE;
    assign is_sfence  = head_i.op == SFENCE_VMA;
    // a dcache flush turns any non-store head into a fence.i
    assign is_fence_i = (head_i.op == FENCE_I) || (flush_dcache_i && head_i.fu != STORE);
    assign fence_any  = is_fence || is_fence_i || is_sfence;

    // fence ops are never handed to the store buffer
    assign is_store   = (head_i.fu == STORE) && !fence_any;
    assign is_csr     = head_i.fu == CSR;

    // ------------------------------
    // retire gates
    // ------------------------------
    // store waits for room in the lsu commit buffer
    assign store_gate = !is_store || commit_lsu_ready_i;
    // csr instruction stalls when the csr file traps
    assign csr_gate   = !is_csr || !csr_exception_i.valid;
    // fences wait for the store buffer to drain
    assign fence_gate = !fence_any || no_st_pending_i;

    assign ack   = retire_ok && store_gate && csr_gate && fence_gate;
    assign ack_o = ack;

    // lsu and flush strobes only fire with the retiring head
    assign commit_lsu_o           = ack && is_store;
    assign fence_req_o.fence      = ack && is_fence;
    assign fence_req_o.fence_i    = ack && is_fence_i;
    assign fence_req_o.sfence_vma = ack && is_sfence;

    // ------------------------------
    // register write
    // ------------------------------
    assign rf_write_o.we_fpr = ack && is_rd_fpr(head_i.op);
    assign rf_write_o.we_gpr = ack && !is_rd_fpr(head_i.op);
    assign rf_write_o.waddr  = head_i.rd;
    // csr instructions return the old csr value
    assign rf_write_o.wdata  = (is_csr && !csr_exception_i.valid) ? csr_rdata_i : head_i.result;

    // ------------------------------
    // csr request
    // ------------------------------
    always_comb begin
        // csr nop by default
        csr_req_o.op           = ADD;
        csr_req_o.wdata        = '0;
        csr_req_o.write_fflags = fflags_we_i;
        csr_req_o.commit       = ack && is_csr;
        // merged flags from both ports
        if (fflags_we_i) begin
            csr_req_o.wdata = {{(XLEN-FFLAGS_BITS){1'b0}}, fflags_i};
        end
        // op and operand of a csr head go out even when it stalls
        if (retire_ok && is_csr) begin
            csr_req_o.op    = head_i.op;
            csr_req_o.wdata = head_i.result;
        end
    end

    // ------------------------------
    // assertions
    // ------------------------------
    a_ack_needs_valid: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ack_o |-> head_i.valid
    );

    // a store commit and a pipeline flush never share a cycle
    a_lsu_fence_excl: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(commit_lsu_o && (|fence_req_o))
    );

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
commit_pkg.sv
trap_select.sv
head_commit.sv
second_commit.sv
fp_state_commit.sv
commit_stage.sv
tb_commit_stage.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the commit stage testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
    --top-module tb_commit_stage -o tb_commit_stage \
    && ./obj_dir/tb_commit_stage | tee /dev/stderr | grep -qF "Simulation completed successfully" \
    && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== second_commit.sv ====
// commit port 1
// lets the second entry retire in the same cycle as the head when safe

`timescale 1ns/1ps
`default_nettype none

module second_commit import commit_pkg::*; (
    input  wire       clk_i,
    input  wire       rst_n_i,
    input  wire       sb_entry_t entry_i,
    input  wire       head_ack_i,
    input  wire       fu_t head_fu_i,
    input  wire       flush_dcache_i,
    input  wire       single_step_i,
    input  wire       exception_valid_i,
    output logic      ack_o,
    output rf_write_t rf_write_o
);

    logic head_ok;
    logic entry_ok;

    // head retires and is no csr instruction, no flush, no stepping, no trap
    assign head_ok = head_ack_i && head_fu_i != CSR && !flush_dcache_i
                     && !single_step_i && !exception_valid_i;

    // only units without side effects at commit may pair up
    assign entry_ok = entry_i.valid && !entry_i.ex.valid
                      && (entry_i.fu inside {ALU, LOAD, CTRL_FLOW, MULT, FPU});

    assign ack_o = head_ok && entry_ok;

    // register write for port 1
    assign rf_write_o.we_fpr = ack_o && is_rd_fpr(entry_i.op);
    assign rf_write_o.we_gpr = ack_o && !is_rd_fpr(entry_i.op);
    assign rf_write_o.waddr  = entry_i.rd;
    assign rf_write_o.wdata  = entry_i.result;

    // ------------------------------
    // assertions
    // ------------------------------
    // retirement stays in order across the two ports
    a_in_order: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ack_o |-> head_ack_i
    );

endmodule

`default_nettype wire

// ==== tb_commit_model.svh ====
// commit stage reference model
// expected outputs per input vector, lfsr bit source and typed compare tasks

`ifndef TB_COMMIT_MODEL_SVH
`define TB_COMMIT_MODEL_SVH

// one input vector as driven on the falling edge
typedef struct packed {
    sb_entry_t [NR_COMMIT_PORTS-1:0] e;
    logic                            halt;
    logic                            flush;
    logic                            step;
    exception_t                      csr_ex;
    logic [XLEN-1:0]                 csr_rdata;
    logic                            lsu_ready;
    logic                            no_st;
} stim_t;

// outputs expected for one vector
typedef struct packed {
    logic [NR_COMMIT_PORTS-1:0]      ack;
    rf_write_t [NR_COMMIT_PORTS-1:0] rf;
    logic                            lsu;
    csr_req_t                        csr;
    fence_req_t                      fence;
    exception_t                      exc;
    logic                            dirty;
} expect_t;

logic [31:0] lfsr_state = 32'h6582_e095;

// ------------------------------
// random bits
// ------------------------------
// galois lfsr stepped once per bit handed out
function automatic logic next_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out)
        lfsr_state = lfsr_state ^ 32'h8020_0003;
    return out;
endfunction

// ------------------------------
// reference model
// ------------------------------
// destinations in the fp register file
function automatic logic fp_dest(op_t op);
    return op inside {FADD, FMUL, FLD};
endfunction

function automatic expect_t commit_model(stim_t s);
    expect_t                x;
    logic                   fen;
    logic                   fen_i;
    logic                   sfen;
    logic                   any_fence;
    logic                   st;
    logic                   csr;
    logic                   ok0;
    logic                   flags_we;
    logic [FFLAGS_BITS-1:0] flags;
    x = '0;
    flags_we = 1'b0;
    flags = '0;
    // an earlier head exception wins over a csr trap, which takes the head tval
    if (s.e[0].valid && s.e[0].ex.valid) begin
        x.exc = s.e[0].ex;
    end else if (s.e[0].valid && s.csr_ex.valid) begin
        x.exc = s.csr_ex;
        x.exc.tval = s.e[0].ex.tval;
    end
    x.exc.valid = x.exc.valid && !s.halt;
    fen = s.e[0].op == FENCE;
    sfen = s.e[0].op == SFENCE_VMA;
    // dcache flush makes a non-store head a fence.i
    fen_i = (s.e[0].op == FENCE_I) || (s.flush && s.e[0].fu != STORE);
    any_fence = fen || fen_i || sfen;
    st = (s.e[0].fu == STORE) && !any_fence;
    csr = s.e[0].fu == CSR;
    ok0 = s.e[0].valid && !s.e[0].ex.valid && !s.halt;
    x.ack[0] = ok0 && (!st || s.lsu_ready) && (!csr || !s.csr_ex.valid)
               && (!any_fence || s.no_st);
    x.ack[1] = x.ack[0] && !csr && !s.flush && !s.step && !x.exc.valid
               && s.e[1].valid && !s.e[1].ex.valid
               && (s.e[1].fu inside {ALU, LOAD, CTRL_FLOW, MULT, FPU});
    for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
        x.rf[i].we_fpr = x.ack[i] && fp_dest(s.e[i].op);
        x.rf[i].we_gpr = x.ack[i] && !fp_dest(s.e[i].op);
        x.rf[i].waddr = s.e[i].rd;
        x.rf[i].wdata = s.e[i].result;
        // fpu results carry fflags in the cause word
        if (x.ack[i] && s.e[i].fu == FPU) begin
            flags_we = 1'b1;
            flags = flags | s.e[i].ex.cause.fp.fflags;
        end
        if (x.ack[i] && (s.e[i].fu == FPU || fp_dest(s.e[i].op)))
            x.dirty = 1'b1;
    end
    if (csr && !s.csr_ex.valid)
        x.rf[0].wdata = s.csr_rdata;
    // csr request stays a nop unless fflags accrue or the head is a csr
    x.csr.op = ADD;
    x.csr.write_fflags = flags_we;
    x.csr.commit = x.ack[0] && csr;
    if (flags_we)
        x.csr.wdata = {{(XLEN - FFLAGS_BITS){1'b0}}, flags};
    if (ok0 && csr) begin
        x.csr.op = s.e[0].op;
        x.csr.wdata = s.e[0].result;
    end
    x.lsu = x.ack[0] && st;
    x.fence.fence = x.ack[0] && fen;
    x.fence.fence_i = x.ack[0] && fen_i;
    x.fence.sfence_vma = x.ack[0] && sfen;
    return x;
endfunction

// ------------------------------
// compare tasks
// ------------------------------
task automatic record_check(string name, logic bad, string exp_s, string act_s);
    checks++;
    if (bad) begin
        errors++;
        $display("FAILED at %0d ns: %s expected %s got %s", $time, name, exp_s, act_s);
    end
endtask

task automatic check_ack(string name, logic [NR_COMMIT_PORTS-1:0] exp,
                         logic [NR_COMMIT_PORTS-1:0] act);
    record_check(name, act !== exp, $sformatf("%b", exp), $sformatf("%b", act));
endtask

task automatic check_rf(string name, rf_write_t exp, rf_write_t act);
    record_check(name, act !== exp, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_csr(string name, csr_req_t exp, csr_req_t act);
    record_check(name, act !== exp, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_fence(string name, fence_req_t exp, fence_req_t act);
    record_check(name, act !== exp, $sformatf("%b", exp), $sformatf("%b", act));
endtask

task automatic check_exc(string name, exception_t exp, exception_t act);
    record_check(name, act !== exp, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_bit(string name, logic exp, logic act);
    record_check(name, act !== exp, $sformatf("%b", exp), $sformatf("%b", act));
endtask

task automatic check_word(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
    record_check(name, act !== exp, $sformatf("%h", exp), $sformatf("%h", act));
endtask

`endif

// ==== tb_commit_stage.sv ====
// commit stage testbench
// directed and lfsr random vectors, checked against a reference model

`timescale 1ns/1ps
`default_nettype none

module tb_commit_stage import commit_pkg::*; ();

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 8;
    localparam int N_RANDOM     = 2000;

    logic clk;
    logic rst_n;
    int   checks = 0;
    int   errors = 0;
    logic built  = 1'b0;

    `include "tb_commit_model.svh"

    stim_t                           stim;
    stim_t                           vec_q[$];
    // dut outputs
    logic [NR_COMMIT_PORTS-1:0]      commit_ack;
    rf_write_t [NR_COMMIT_PORTS-1:0] rf_write;
    logic [XLEN-1:0]                 pc;
    logic [TRANS_ID_BITS-1:0]        tran_id;
    exception_t                      exception;
    logic                            dirty_fp;
    csr_req_t                        csr_req;
    logic                            commit_lsu;
    fence_req_t                      fence_req;

    commit_stage dut_i (
        .clk_i              (clk),
        .rst_n_i            (rst_n),
        .halt_i             (stim.halt),
        .flush_dcache_i     (stim.flush),
        .single_step_i      (stim.step),
        .exception_o        (exception),
        .dirty_fp_state_o   (dirty_fp),
        .commit_instr_i     (stim.e),
        .commit_ack_o       (commit_ack),
        .rf_write_o         (rf_write),
        .pc_o               (pc),
        .csr_req_o          (csr_req),
        .csr_rdata_i        (stim.csr_rdata),
        .csr_exception_i    (stim.csr_ex),
        .commit_lsu_o       (commit_lsu),
        .commit_lsu_ready_i (stim.lsu_ready),
        .commit_tran_id_o   (tran_id),
        .no_st_pending_i    (stim.no_st),
        .fence_req_o        (fence_req)
    );

    // ------------------------------
    // stimulus helpers
    // ------------------------------
    // two valid entries with the lsu ready and the store buffer empty
    function automatic stim_t pair(fu_t fu0, op_t op0, fu_t fu1, op_t op1);
        stim_t s;
        s = '0;
        s.lsu_ready = 1'b1;
        s.no_st = 1'b1;
        s.csr_rdata = 32'h5a5a_0001;
        s.csr_ex.cause.code = 8'd2;
        s.csr_ex.tval = 32'hffff_0000;
        for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
            s.e[i].valid = 1'b1;
            s.e[i].pc = 32'h8000_0000 + 4 * i;
            s.e[i].trans_id = 3'(i + 2);
            s.e[i].rd = 5'(3 + 4 * i);
            s.e[i].result = 32'h1234_5670 + i;
            s.e[i].ex.tval = 32'h0000_0a00 + i;
        end
        s.e[0].fu = fu0;
        s.e[0].op = op0;
        s.e[1].fu = fu1;
        s.e[1].op = op1;
        return s;
    endfunction

    function automatic stim_t random_stim();
        stim_t s;
        for (int i = 0; i < $bits(stim_t); i++)
            s[i] = next_bit();
        for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
            // fold unused codes back onto legal operations
            if (s.e[i].op > FLD)
                s.e[i].op = op_t'(s.e[i].op - 5'd16);
            s.e[i].valid = next_bit() | next_bit();
            s.e[i].ex.valid = next_bit() & next_bit() & next_bit();
        end
        // rare control events
        s.halt = next_bit() & next_bit() & next_bit();
        s.flush = next_bit() & next_bit() & next_bit();
        s.step = next_bit() & next_bit() & next_bit();
        s.csr_ex.valid = next_bit() & next_bit();
        return s;
    endfunction

    initial begin : clock_gen
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin : drive_stimulus
        stim_t s;
        op_t   fence_ops[3];
        fence_ops = '{FENCE, FENCE_I, SFENCE_VMA};
        // idle during reset with no entries and halt high
        stim = '0;
        stim.halt = 1'b1;
        rst_n = 1'b0;
        vec_q.push_back(pair(ALU, ADD, LOAD, SUB));
        vec_q.push_back(pair(MULT, XORL, FPU, FADD));
        s = pair(ALU, ORL, CTRL_FLOW, ADD);
        s.step = 1'b1;
        vec_q.push_back(s);
        // flush turns the alu head into a fence.i
        s.step = 1'b0;
        s.flush = 1'b1;
        vec_q.push_back(s);
        s.no_st = 1'b0;
        vec_q.push_back(s);
        s = pair(STORE, ADD, ALU, ADD);
        vec_q.push_back(s);
        s.lsu_ready = 1'b0;
        vec_q.push_back(s);
        vec_q.push_back(pair(ALU, ADD, STORE, ADD));
        s = pair(CSR, CSR_SET, ALU, ADD);
        vec_q.push_back(s);
        s.csr_ex.valid = 1'b1;
        vec_q.push_back(s);
        foreach (fence_ops[i]) begin
            s = pair(ALU, fence_ops[i], ALU, ADD);
            s.no_st = 1'b0;
            vec_q.push_back(s);
            s.no_st = 1'b1;
            vec_q.push_back(s);
        end
        s = pair(FPU, FADD, FPU, FMUL);
        s.e[0].ex.cause.code = 8'h03;
        s.e[1].ex.cause.code = 8'h14;
        vec_q.push_back(s);
        // head exception against a csr trap and the same vector halted
        s = pair(ALU, ADD, ALU, ADD);
        s.e[0].ex.valid = 1'b1;
        s.e[0].ex.cause.code = 8'd12;
        s.csr_ex.valid = 1'b1;
        vec_q.push_back(s);
        s.halt = 1'b1;
        vec_q.push_back(s);
        repeat (N_RANDOM) vec_q.push_back(random_stim());
        built = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        foreach (vec_q[i]) begin
            stim = vec_q[i];
            @(negedge clk);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Simulation completed successfully");
        end else begin
            if (checks == 0)
                $display("no outputs were checked");
            $display("Simulation failed");
        end
        $finish;
    end

    // ------------------------------
    // checking and watchdog
    // ------------------------------
    initial begin : check_outputs
        expect_t x;
        wait (rst_n);
        forever begin
            @(posedge clk);
            x = commit_model(stim);
            check_ack("commit_ack_o", x.ack, commit_ack);
            check_rf("rf_write_o[0]", x.rf[0], rf_write[0]);
            check_rf("rf_write_o[1]", x.rf[1], rf_write[1]);
            check_csr("csr_req_o", x.csr, csr_req);
            check_fence("fence_req_o", x.fence, fence_req);
            check_exc("exception_o", x.exc, exception);
            check_bit("commit_lsu_o", x.lsu, commit_lsu);
            check_bit("dirty_fp_state_o", x.dirty, dirty_fp);
            check_word("pc_o", stim.e[0].pc, pc);
            check_word("commit_tran_id_o", XLEN'(stim.e[0].trans_id), XLEN'(tran_id));
        end
    end

    initial begin : watchdog
        wait (built);
        #(2 * vec_q.size() * PERIOD + RESET_CYCLES * PERIOD);
        $display("timeout: the vectors did not finish in the expected run time");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== trap_select.sv ====
// exception select
// picks the trap sent to the controller from the head entry and csr file

`timescale 1ns/1ps
`default_nettype none

module trap_select import commit_pkg::*; (
    input  wire        clk_i,
    input  wire        rst_n_i,
    input  wire        sb_entry_t  head_i,
    input  wire        exception_t csr_exception_i,
    input  wire        halt_i,
    output exception_t exception_o
);

    always_comb begin
        exception_o = '0;
        // only a valid head can trap
        if (head_i.valid) begin
            // csr trap or interrupt keeps the tval of the head entry
            if (csr_exception_i.valid) begin
                exception_o      = csr_exception_i;
                exception_o.tval = head_i.ex.tval;
            end
            // an earlier exception (e.g. fetch page fault) has priority
            if (head_i.ex.valid) begin
                exception_o = head_i.ex;
            end
        end
        // nothing is taken while halted
        if (halt_i) begin
            exception_o.valid = 1'b0;
        end
    end

    // ------------------------------
    // assertions
    // ------------------------------
    // an empty commit slot never raises a trap
    a_no_exc_without_head: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !head_i.valid |-> !exception_o.valid
    );

endmodule

`default_nettype wire
